//--- Makefile
SIM := obj_dir/datapathSim
SRCS := datapath.f $(wildcard common/*.sv common/*.svh alu/*.sv rtl/*.sv tests/*.sv)

all: run

$(SIM): $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f datapath.f \
		--top-module datapathTb --Mdir obj_dir -o datapathSim

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

//--- alu/alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "datapath_config.svh"

// Combinational ALU. Y is operand A and the bus is operand B.
module alu
(
    input  wire logic [`DATA_WIDTH-1:0] yData,
    input  wire logic [`DATA_WIDTH-1:0] busData,
    input  wire isaPkg::opcodeE         opcode,
    input  wire logic                   incPc,
    output datapathPkg::aluResultT      result
);

    logic [$clog2(`DATA_WIDTH)-1:0] shiftCount;
    logic signed [2*`DATA_WIDTH-1:0] product;
    logic [`DATA_WIDTH-1:0] rotRight;
    logic [`DATA_WIDTH-1:0] rotLeft;

    assign shiftCount = busData[$clog2(`DATA_WIDTH)-1:0];

    // Signed multiply over the full width of both words.
    assign product = $signed(yData) * $signed(busData);

    // A shift by the full width gives zero, so a count of zero rotates by nothing.
    assign rotRight = (yData >> shiftCount) | (yData << (`DATA_WIDTH - shiftCount));
    assign rotLeft  = (yData << shiftCount) | (yData >> (`DATA_WIDTH - shiftCount));

    always_comb
    begin
        result = '0; // Unsupported opcodes give zero.
        if (incPc)
        begin
            result.lo = busData + 1'b1; // PC increment ignores the opcode.
        end
        else
        begin
            case (opcode)
                isaPkg::add:
                    result.lo = yData + busData;
                isaPkg::sub:
                    result.lo = yData - busData;
                isaPkg::andOp:
                    result.lo = yData & busData;
                isaPkg::orOp:
                    result.lo = yData | busData;
                isaPkg::shr:
                    result.lo = yData >> shiftCount; // Logical shift.
                isaPkg::shl:
                    result.lo = yData << shiftCount;
                isaPkg::ror:
                    result.lo = rotRight;
                isaPkg::rol:
                    result.lo = rotLeft;
                isaPkg::mul:
                begin
                    result.hi = product[2*`DATA_WIDTH-1:`DATA_WIDTH];
                    result.lo = product[`DATA_WIDTH-1:0];
                end
                isaPkg::neg:
                    result.lo = -busData;
                isaPkg::notOp:
                    result.lo = ~busData;
                default:
                    result = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- common/datapathPkg.sv
`default_nettype none

`include "datapath_config.svh"

package datapathPkg;

    // Control strobes from the sequencer, each one valid for a single cycle.
    typedef struct packed {
        logic [`NUM_REGS-1:0] regIn;  // Load mask with R0 in bit 0.
        logic [`NUM_REGS-1:0] regOut; // Drive mask with R0 in bit 0.
        logic pcIn;
        logic pcOut;
        logic irIn;
        logic yIn;
        logic zIn;
        logic zLowOut;
        logic zHighOut;
        logic marIn;
        logic mdrIn;
        logic mdrOut;
        logic read;  // MDR takes memory data instead of the bus.
        logic cOut;  // Sign-extended immediate onto the bus.
        logic incPc; // ALU returns bus plus one.
    } ctrlT;

    // Full ALU result. Only mul sets hi.
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] hi;
        logic [`DATA_WIDTH-1:0] lo;
    } aluResultT;

endpackage

`default_nettype wire

//--- common/datapath_config.svh
`ifndef DATAPATH_CONFIG_SVH
`define DATAPATH_CONFIG_SVH

// Bus, register and ALU operand width.
`define DATA_WIDTH 32

// General purpose registers R0 to R15.
`define NUM_REGS 16

`define OPCODE_WIDTH 5 // Top bits of every instruction word.
`define IMM_WIDTH 19 // Immediate field of the I format.

`endif

//--- common/isaPkg.sv
`default_nettype none

`include "datapath_config.svh"

package isaPkg;

    // Register select field of 4 bits for sixteen registers.
    typedef logic [$clog2(`NUM_REGS)-1:0] regSelT;

    typedef enum logic [`OPCODE_WIDTH-1:0] {
        ld    = 5'd0,
        ldi   = 5'd1,
        st    = 5'd2,
        add   = 5'd3,
        sub   = 5'd4,
        shr   = 5'd5,
        shl   = 5'd6,
        ror   = 5'd7,
        rol   = 5'd8,
        andOp = 5'd9,
        orOp  = 5'd10,
        mul   = 5'd14,
        neg   = 5'd16,
        notOp = 5'd17
    } opcodeE;

    // Three register operands.
    typedef struct packed {
        opcodeE opcode;
        regSelT ra;
        regSelT rb;
        regSelT rc;
        logic [`DATA_WIDTH-`OPCODE_WIDTH-3*$clog2(`NUM_REGS)-1:0] unused;
    } rFormatT;

    // Two registers and a signed immediate.
    typedef struct packed {
        opcodeE opcode;
        regSelT ra;
        regSelT rb;
        logic [`IMM_WIDTH-1:0] imm;
    } iFormatT;

    typedef union packed {
        rFormatT rFmt;
        iFormatT iFmt;
    } instructionU;

endpackage

`default_nettype wire

//--- datapath.f
+incdir+common
common/isaPkg.sv
common/datapathPkg.sv
alu/alu.sv
rtl/registerFile.sv
rtl/memoryInterface.sv
rtl/busMux.sv
rtl/datapath.sv
tests/datapathChecker.sv
tests/datapathTb.sv

//--- rtl/busMux.sv
`timescale 1ns/1ns
`default_nettype none

`include "datapath_config.svh"

// Single bus driver select. Only one source should drive per cycle;
// the fixed order below settles any overlap.
module busMux
(
    input  wire datapathPkg::ctrlT      ctrl,
    input  wire logic [`DATA_WIDTH-1:0] regData,
    input  wire logic [`DATA_WIDTH-1:0] pcData,
    input  wire logic [`DATA_WIDTH-1:0] mdrData,
    input  wire datapathPkg::aluResultT zData,
    input  wire logic [`DATA_WIDTH-1:0] cData,
    output logic      [`DATA_WIDTH-1:0] busData
);

    always_comb
    begin
        if (|ctrl.regOut)
        begin
            busData = regData; // Register file already picked one.
        end
        else if (ctrl.pcOut)
        begin
            busData = pcData;
        end
        else if (ctrl.mdrOut)
        begin
            busData = mdrData;
        end
        else if (ctrl.zLowOut)
        begin
            busData = zData.lo;
        end
        else if (ctrl.zHighOut)
        begin
            busData = zData.hi;
        end
        else if (ctrl.cOut)
        begin
            busData = cData; // Immediate from IR.
        end
        else
        begin
            busData = '0; // Idle bus reads zero.
        end
    end

endmodule

`default_nettype wire

//--- rtl/datapath.sv
`timescale 1ns/1ns
`default_nettype none

`include "datapath_config.svh"

// Single-bus datapath, one control step per cycle.
module datapath
(
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire datapathPkg::ctrlT      ctrl,
    input  wire logic [`DATA_WIDTH-1:0] memDataIn,
    output logic      [`DATA_WIDTH-1:0] busData,
    output logic      [`DATA_WIDTH-1:0] memAddr,
    output logic      [`DATA_WIDTH-1:0] memDataOut
);

    logic [`DATA_WIDTH-1:0] pc;
    isaPkg::instructionU    ir;
    logic [`DATA_WIDTH-1:0] y;
    datapathPkg::aluResultT z;
    datapathPkg::aluResultT aluResult;
    logic [`DATA_WIDTH-1:0] regData;
    logic [`DATA_WIDTH-1:0] cData;

    // I view of IR, sign-extended to the bus width.
    assign cData = {{(`DATA_WIDTH - `IMM_WIDTH){ir.iFmt.imm[`IMM_WIDTH-1]}}, ir.iFmt.imm};

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            pc <= '0;
            ir <= '0;
            y  <= '0;
            z  <= '0;
        end
        else
        begin
            if (ctrl.pcIn)
                pc <= busData;
            if (ctrl.irIn)
                ir <= busData; // Both views follow the whole word.
            if (ctrl.yIn)
                y <= busData;
            if (ctrl.zIn)
                z <= aluResult;
        end
    end

    registerFile registerFile_i (.clk(clk), .rstN(rstN), .busData(busData),
        .regIn(ctrl.regIn), .regOut(ctrl.regOut), .regData(regData));

    memoryInterface memoryInterface_i (.clk(clk), .rstN(rstN), .busData(busData),
        .memDataIn(memDataIn), .marIn(ctrl.marIn), .mdrIn(ctrl.mdrIn), .read(ctrl.read),
        .marData(memAddr), .mdrData(memDataOut));

    busMux busMux_i (.ctrl(ctrl), .regData(regData), .pcData(pc), .mdrData(memDataOut),
        .zData(z), .cData(cData), .busData(busData));

    // Opcode comes from the R view of IR.
    alu alu_i (.yData(y), .busData(busData), .opcode(ir.rFmt.opcode),
        .incPc(ctrl.incPc), .result(aluResult));

endmodule

`default_nettype wire

//--- rtl/memoryInterface.sv
`timescale 1ns/1ns
`default_nettype none

`include "datapath_config.svh"

// Address and data registers that face the external memory.
module memoryInterface
(
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic [`DATA_WIDTH-1:0] busData,
    input  wire logic [`DATA_WIDTH-1:0] memDataIn,
    input  wire logic                   marIn,
    input  wire logic                   mdrIn,
    input  wire logic                   read,
    output logic      [`DATA_WIDTH-1:0] marData,
    output logic      [`DATA_WIDTH-1:0] mdrData
);

    logic [`DATA_WIDTH-1:0] mdrNext;

    // Memory word on a read, bus word on a write setup.
    assign mdrNext = read ? memDataIn : busData;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            marData <= '0;
            mdrData <= '0;
        end
        else
        begin
            if (marIn)
                marData <= busData;
            if (mdrIn)
                mdrData <= mdrNext;
        end
    end

endmodule

`default_nettype wire

//--- rtl/registerFile.sv
`timescale 1ns/1ns
`default_nettype none

`include "datapath_config.svh"

// General registers R0 to R15 with a single read port onto the bus.
module registerFile
(
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic [`DATA_WIDTH-1:0] busData,
    input  wire logic [`NUM_REGS-1:0]   regIn,
    input  wire logic [`NUM_REGS-1:0]   regOut,
    output logic      [`DATA_WIDTH-1:0] regData
);

    logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];

    // Several registers may load the same bus word in one cycle.
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < `NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < `NUM_REGS; i++)
            begin
                if (regIn[i])
                begin
                    regs[i] <= busData;
                end
            end
        end
    end

    // Walk down so the lowest driven register wins.
    always_comb
    begin
        regData = '0;
        for (int i = `NUM_REGS - 1; i >= 0; i--)
        begin
            if (regOut[i])
            begin
                regData = regs[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/datapathChecker.sv
`timescale 1ns/1ns
`default_nettype none

`include "datapath_config.svh"

// Bus and reset rules of the datapath.
module datapathChecker
(
    input wire logic                   clk,
    input wire logic                   rstN,
    input wire datapathPkg::ctrlT      ctrl,
    input wire logic [`DATA_WIDTH-1:0] busData,
    input wire logic [`DATA_WIDTH-1:0] memAddr
);

    logic [5:0] drivers;

    // The register file resolves its own mask, so it counts as one source.
    assign drivers = {|ctrl.regOut, ctrl.pcOut, ctrl.mdrOut, ctrl.zLowOut, ctrl.zHighOut,
        ctrl.cOut};

    oneDriver: assert property (@(posedge clk) disable iff (!rstN) $countones(drivers) <= 1)
        else $error("more than one source drives the bus");

    idleBusZero: assert property (@(posedge clk) disable iff (!rstN)
        drivers == '0 |-> busData == '0)
        else $error("bus is not zero with no driver");

    resetAddrZero: assert property (@(posedge clk) !rstN |-> memAddr == '0)
        else $error("memAddr is not zero during reset");

endmodule

bind datapath datapathChecker datapathChecker_i (.clk(clk), .rstN(rstN), .ctrl(ctrl),
    .busData(busData), .memAddr(memAddr));

`default_nettype wire

//--- tests/datapathTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "datapath_config.svh"

module datapathTb;

    localparam int CycleLimit = 400; // Tests take about 300 cycles.

    logic clk;
    logic rstN;
    datapathPkg::ctrlT ctrl;
    logic [`DATA_WIDTH-1:0] memDataIn;
    logic [`DATA_WIDTH-1:0] busData;
    logic [`DATA_WIDTH-1:0] memAddr;
    logic [`DATA_WIDTH-1:0] memDataOut;

    logic [`DATA_WIDTH-1:0] expRegs [`NUM_REGS]; // Model of R0 to R15.
    logic [`DATA_WIDTH-1:0] stepBus;
    int seed;
    int checks;
    int errors;
    int cycles;

    datapath datapath_i (.clk(clk), .rstN(rstN), .ctrl(ctrl), .memDataIn(memDataIn),
        .busData(busData), .memAddr(memAddr), .memDataOut(memDataOut));

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit)
        begin
            $display("Timeout: the tests did not finish within %0d cycles.", CycleLimit);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic checkValue(input string what, input logic [31:0] actual,
        input logic [31:0] expected);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Expected ALU result, written from the opcode rules.
    function automatic logic [63:0] aluModel(input logic [4:0] op, input logic [31:0] a,
        input logic [31:0] b);
        logic [63:0] twice;
        logic signed [63:0] wideA;
        logic signed [63:0] wideB;
        logic [4:0] n;
        twice = {a, a};
        wideA = {{32{a[31]}}, a};
        wideB = {{32{b[31]}}, b};
        n = b[4:0];
        case (op)
            isaPkg::add:   return {32'h0, a + b};
            isaPkg::sub:   return {32'h0, a - b};
            isaPkg::andOp: return {32'h0, a & b};
            isaPkg::orOp:  return {32'h0, a | b};
            isaPkg::shr:   return {32'h0, a >> n};
            isaPkg::shl:   return {32'h0, a << n};
            isaPkg::ror:   return {32'h0, twice[n +: 32]};
            isaPkg::rol:   return {32'h0, twice[63 - n -: 32]};
            isaPkg::mul:   return wideA * wideB;
            isaPkg::neg:   return {32'h0, 32'h0 - b};
            isaPkg::notOp: return {32'h0, ~b};
            default:       return 64'h0;
        endcase
    endfunction

    // One control step, held for a single cycle.
    task automatic applyStep(input datapathPkg::ctrlT c, input logic [31:0] mem);
        @(posedge clk);
        ctrl <= c;
        memDataIn <= mem;
        @(negedge clk);
        stepBus = busData;
        @(posedge clk);
        ctrl <= '0;
        memDataIn <= '0;
        @(negedge clk); // Loaded registers are stable here.
    endtask

    task automatic checkBusFrom(input string what, input datapathPkg::ctrlT c,
        input logic [31:0] expected);
        applyStep(c, '0);
        checkValue(what, stepBus, expected);
    endtask

    task automatic readMemory(input logic [31:0] value);
        datapathPkg::ctrlT c;
        c = '0;
        c.read = 1'b1;
        c.mdrIn = 1'b1;
        applyStep(c, value);
    endtask

    // Memory word into MDR, then MDR onto the bus into the destination.
    task automatic loadViaMdr(input logic [31:0] value, input datapathPkg::ctrlT dest);
        datapathPkg::ctrlT c;
        readMemory(value);
        c = dest;
        c.mdrOut = 1'b1;
        applyStep(c, '0);
    endtask

    task automatic loadRegister(input int r, input logic [31:0] value);
        datapathPkg::ctrlT c;
        c = '0;
        c.regIn[r] = 1'b1;
        loadViaMdr(value, c);
        expRegs[r] = value;
    endtask

    task automatic resetTest();
        datapathPkg::ctrlT c;
        for (int r = 0; r < `NUM_REGS; r++)
        begin
            c = '0;
            c.regOut[r] = 1'b1;
            checkBusFrom($sformatf("R%0d after reset", r), c, '0);
        end
        c = '0;
        c.pcOut = 1'b1;
        checkBusFrom("PC after reset", c, '0);
        c = '0;
        c.mdrOut = 1'b1;
        checkBusFrom("MDR after reset", c, '0);
        c = '0;
        c.zLowOut = 1'b1;
        checkBusFrom("Z low after reset", c, '0);
        checkValue("memAddr after reset", memAddr, '0);
    endtask

    task automatic memoryLoadTest();
        logic [31:0] values [3];
        int dests [3];
        datapathPkg::ctrlT c;
        values = '{32'hFA92, 32'hFF, 32'h595};
        dests = '{4, 5, 0};
        for (int i = 0; i < 3; i++)
        begin
            loadRegister(dests[i], values[i]);
            c = '0;
            c.regOut[dests[i]] = 1'b1;
            checkBusFrom($sformatf("R%0d after load", dests[i]), c, expRegs[dests[i]]);
        end
        checkValue("memDataOut after loads", memDataOut, 32'h595);
    endtask

    task automatic fetchSubTest();
        datapathPkg::ctrlT c;
        c = '0;
        c.pcOut = 1'b1;
        c.marIn = 1'b1;
        c.incPc = 1'b1;
        c.zIn = 1'b1;
        applyStep(c, '0);
        c = '0;
        c.zLowOut = 1'b1;
        c.pcIn = 1'b1;
        c.read = 1'b1;
        c.mdrIn = 1'b1;
        applyStep(c, 32'h2022_8000); // sub R0, R4, R5.
        c = '0;
        c.mdrOut = 1'b1;
        c.irIn = 1'b1;
        applyStep(c, '0);
        c = '0;
        c.regOut[4] = 1'b1;
        c.yIn = 1'b1;
        applyStep(c, '0);
        c = '0;
        c.regOut[5] = 1'b1;
        c.zIn = 1'b1;
        applyStep(c, '0);
        c = '0;
        c.zLowOut = 1'b1;
        c.regIn[0] = 1'b1;
        applyStep(c, '0);
        expRegs[0] = 32'hF993; // 0xFA92 minus 0xFF.
        checkValue("memAddr after fetch", memAddr, '0);
        c = '0;
        c.pcOut = 1'b1;
        checkBusFrom("PC after fetch", c, 32'h1);
        c = '0;
        c.regOut[0] = 1'b1;
        checkBusFrom("R0 after sub", c, expRegs[0]);
    endtask

    task automatic aluTest();
        logic [4:0] ops [13];
        logic [31:0] a;
        logic [31:0] b;
        logic [63:0] expected;
        datapathPkg::ctrlT c;
        ops = '{isaPkg::add, isaPkg::sub, isaPkg::shr, isaPkg::shl, isaPkg::ror, isaPkg::rol,
            isaPkg::andOp, isaPkg::orOp, isaPkg::mul, isaPkg::neg, isaPkg::notOp, 5'd11, 5'd31};
        for (int i = 0; i < 13; i++)
        begin
            a = $random(seed);
            b = $random(seed);
            expected = aluModel(ops[i], a, b);
            c = '0;
            c.irIn = 1'b1;
            loadViaMdr({ops[i], 27'h0}, c);
            c = '0;
            c.yIn = 1'b1;
            loadViaMdr(a, c);
            readMemory(b);
            c = '0;
            c.mdrOut = 1'b1;
            c.zIn = 1'b1;
            applyStep(c, '0);
            c = '0;
            c.zLowOut = 1'b1;
            checkBusFrom($sformatf("Z low for opcode %0d", ops[i]), c, expected[31:0]);
            if (ops[i] == isaPkg::mul)
            begin
                c = '0;
                c.zHighOut = 1'b1;
                checkBusFrom("Z high for mul", c, expected[63:32]);
            end
        end
    endtask

    task automatic immediateTest();
        isaPkg::iFormatT word;
        logic [`IMM_WIDTH-1:0] imms [2];
        logic [31:0] exps [2];
        datapathPkg::ctrlT c;
        imms = '{19'h1_2345, 19'h4_0F0F}; // Positive, then negative.
        exps = '{32'h0001_2345, 32'hFFFC_0F0F};
        for (int i = 0; i < 2; i++)
        begin
            word = '0;
            word.opcode = isaPkg::ldi;
            word.ra = 4'd2;
            word.imm = imms[i];
            c = '0;
            c.irIn = 1'b1;
            loadViaMdr(word, c);
            c = '0;
            c.cOut = 1'b1;
            checkBusFrom($sformatf("immediate %h", imms[i]), c, exps[i]);
        end
    endtask

    task automatic marPriorityTest();
        datapathPkg::ctrlT c;
        logic [31:0] value;
        c = '0;
        c.regOut[4] = 1'b1;
        c.marIn = 1'b1;
        applyStep(c, '0);
        checkValue("memAddr from R4", memAddr, expRegs[4]);
        value = $random(seed);
        loadRegister(1, value);
        c = '0;
        c.regOut[0] = 1'b1;
        c.regOut[1] = 1'b1; // Lowest register wins.
        checkBusFrom("bus with R0 and R1 driven", c, expRegs[0]);
    endtask

    initial
    begin
        seed = 32'ha8be_92d7;
        clk = 1'b0;
        rstN = 1'b0;
        ctrl = '0;
        memDataIn = '0;
        checks = 0;
        errors = 0;
        cycles = 0;
        for (int r = 0; r < `NUM_REGS; r++)
        begin
            expRegs[r] = '0;
        end
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        resetTest();
        memoryLoadTest();
        fetchSubTest();
        aluTest();
        immediateTest();
        marPriorityTest();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
